//--- design/rs_div_pkg.sv
`default_nettype none

package rs_div_pkg;

    localparam int RS_ENTRIES = 8;
    localparam int TAG_W      = 8;
    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;

    // divide unit opcodes
    typedef enum logic [3:0] {
        OP_DIV  = 4'd0,
        OP_DIVU = 4'd1,
        OP_REM  = 4'd2,
        OP_REMU = 4'd3
    } div_op_e;

endpackage

`default_nettype wire

//--- design/rs_div_priority_select.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div_priority_select (
    input  logic [rs_div_pkg::RS_ENTRIES-1:0] req,
    output logic [rs_div_pkg::RS_ENTRIES-1:0] grant,
    output logic                              any
);

    // walk from the top so the lowest set bit is the last one written
    always_comb begin
        grant = '0;
        for (int i = rs_div_pkg::RS_ENTRIES - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
    end

    assign any = |req;

endmodule

`default_nettype wire

//--- design/rs_div_entries.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div_entries (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              alloc_en,
    input  logic [rs_div_pkg::RS_ENTRIES-1:0] alloc_grant,
    input  logic [rs_div_pkg::PC_W-1:0]       disp_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]      disp_rd,
    input  rs_div_pkg::div_op_e               disp_op,
    input  logic [rs_div_pkg::TAG_W-1:0]      disp_src1_tag,
    input  logic [rs_div_pkg::DATA_W-1:0]     disp_src1_data,
    input  logic                              disp_src1_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]      disp_src2_tag,
    input  logic [rs_div_pkg::DATA_W-1:0]     disp_src2_data,
    input  logic                              disp_src2_valid,
    input  logic                              alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]      alu_tag,
    input  logic [rs_div_pkg::DATA_W-1:0]     alu_data,
    input  logic                              mul_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]      mul_tag,
    input  logic [rs_div_pkg::DATA_W-1:0]     mul_data,
    input  logic                              issue_take,
    input  logic [rs_div_pkg::RS_ENTRIES-1:0] issue_grant,
    output logic [rs_div_pkg::RS_ENTRIES-1:0] free_vec,
    output logic [rs_div_pkg::RS_ENTRIES-1:0] ready_vec,
    output logic [rs_div_pkg::PC_W-1:0]       sel_pc,
    output logic [rs_div_pkg::TAG_W-1:0]      sel_rd,
    output rs_div_pkg::div_op_e               sel_op,
    output logic [rs_div_pkg::DATA_W-1:0]     sel_src1,
    output logic [rs_div_pkg::DATA_W-1:0]     sel_src2
);

    logic [rs_div_pkg::RS_ENTRIES-1:0] busy;
    logic [rs_div_pkg::RS_ENTRIES-1:0] src1_ok;
    logic [rs_div_pkg::RS_ENTRIES-1:0] src2_ok;
    logic [rs_div_pkg::RS_ENTRIES-1:0] wake1;
    logic [rs_div_pkg::RS_ENTRIES-1:0] wake2;

    logic [rs_div_pkg::PC_W-1:0]   pc_q   [rs_div_pkg::RS_ENTRIES];
    logic [rs_div_pkg::TAG_W-1:0]  rd_q   [rs_div_pkg::RS_ENTRIES];
    rs_div_pkg::div_op_e           op_q   [rs_div_pkg::RS_ENTRIES];
    logic [rs_div_pkg::TAG_W-1:0]  tag1_q [rs_div_pkg::RS_ENTRIES];
    logic [rs_div_pkg::TAG_W-1:0]  tag2_q [rs_div_pkg::RS_ENTRIES];
    logic [rs_div_pkg::DATA_W-1:0] data1_q[rs_div_pkg::RS_ENTRIES];
    logic [rs_div_pkg::DATA_W-1:0] data2_q[rs_div_pkg::RS_ENTRIES];

    logic                          disp1_ok;
    logic                          disp2_ok;
    logic [rs_div_pkg::DATA_W-1:0] disp1_data;
    logic [rs_div_pkg::DATA_W-1:0] disp2_data;

    function automatic logic bus_hit(input logic [rs_div_pkg::TAG_W-1:0] tag);
        return (alu_valid && alu_tag == tag) || (mul_valid && mul_tag == tag);
    endfunction

    // alu wins when both buses carry the tag
    function automatic logic [rs_div_pkg::DATA_W-1:0] bus_data(
        input logic [rs_div_pkg::TAG_W-1:0] tag
    );
        return (alu_valid && alu_tag == tag) ? alu_data : mul_data;
    endfunction

    // same-cycle bypass for the operands on the dispatch port
    always_comb begin
        disp1_ok   = disp_src1_valid || bus_hit(disp_src1_tag);
        disp2_ok   = disp_src2_valid || bus_hit(disp_src2_tag);
        disp1_data = disp_src1_valid ? disp_src1_data : bus_data(disp_src1_tag);
        disp2_data = disp_src2_valid ? disp_src2_data : bus_data(disp_src2_tag);
    end

    always_comb begin
        for (int i = 0; i < rs_div_pkg::RS_ENTRIES; i++) begin
            wake1[i] = busy[i] && !src1_ok[i] && bus_hit(tag1_q[i]);
            wake2[i] = busy[i] && !src2_ok[i] && bus_hit(tag2_q[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= '0;
            src1_ok <= '0;
            src2_ok <= '0;
        end else begin
            for (int i = 0; i < rs_div_pkg::RS_ENTRIES; i++) begin
                if (alloc_en && alloc_grant[i]) begin
                    busy[i]    <= 1'b1;
                    src1_ok[i] <= disp1_ok;
                    src2_ok[i] <= disp2_ok;
                end else begin
                    if (issue_take && issue_grant[i]) begin
                        busy[i] <= 1'b0; // moved into issue reg
                    end
                    if (wake1[i]) begin
                        src1_ok[i] <= 1'b1;
                    end
                    if (wake2[i]) begin
                        src2_ok[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_div_pkg::RS_ENTRIES; i++) begin
            if (alloc_en && alloc_grant[i]) begin
                pc_q[i]    <= disp_pc;
                rd_q[i]    <= disp_rd;
                op_q[i]    <= disp_op;
                tag1_q[i]  <= disp_src1_tag;
                tag2_q[i]  <= disp_src2_tag;
                data1_q[i] <= disp1_data;
                data2_q[i] <= disp2_data;
            end else begin
                if (wake1[i]) begin
                    data1_q[i] <= bus_data(tag1_q[i]);
                end
                if (wake2[i]) begin
                    data2_q[i] <= bus_data(tag2_q[i]);
                end
            end
        end
    end

    assign free_vec  = ~busy;
    assign ready_vec = busy & src1_ok & src2_ok;

    always_comb begin
        sel_pc   = '0;
        sel_rd   = '0;
        sel_op   = rs_div_pkg::OP_DIV;
        sel_src1 = '0;
        sel_src2 = '0;
        for (int i = 0; i < rs_div_pkg::RS_ENTRIES; i++) begin
            if (issue_grant[i]) begin // grant is one-hot
                sel_pc   = pc_q[i];
                sel_rd   = rd_q[i];
                sel_op   = op_q[i];
                sel_src1 = data1_q[i];
                sel_src2 = data2_q[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rs_div_issue_reg.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div_issue_reg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cand_valid,
    input  logic [rs_div_pkg::PC_W-1:0]   cand_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  cand_rd,
    input  rs_div_pkg::div_op_e           cand_op,
    input  logic [rs_div_pkg::DATA_W-1:0] cand_src1,
    input  logic [rs_div_pkg::DATA_W-1:0] cand_src2,
    input  logic                          iss_ready,
    output logic                          take,
    output logic                          iss_valid,
    output logic [rs_div_pkg::PC_W-1:0]   iss_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  iss_rd,
    output rs_div_pkg::div_op_e           iss_op,
    output logic [rs_div_pkg::DATA_W-1:0] iss_src1,
    output logic [rs_div_pkg::DATA_W-1:0] iss_src2
);

    // load when empty or draining this cycle
    assign take = cand_valid && (!iss_valid || iss_ready);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else if (take) begin
            iss_valid <= 1'b1;
        end else if (iss_ready) begin
            iss_valid <= 1'b0; // drained, nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            iss_pc   <= cand_pc;
            iss_rd   <= cand_rd;
            iss_op   <= cand_op;
            iss_src1 <= cand_src1;
            iss_src2 <= cand_src2;
        end
    end

endmodule

`default_nettype wire

//--- design/rs_div.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  logic [rs_div_pkg::PC_W-1:0]   disp_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_rd,
    input  rs_div_pkg::div_op_e           disp_op,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src1_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_src1_data,
    input  logic                          disp_src1_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src2_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_src2_data,
    input  logic                          disp_src2_valid,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_data,
    input  logic                          mul_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  mul_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] mul_data,
    output logic                          iss_valid,
    input  logic                          iss_ready,
    output logic [rs_div_pkg::PC_W-1:0]   iss_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  iss_rd,
    output rs_div_pkg::div_op_e           iss_op,
    output logic [rs_div_pkg::DATA_W-1:0] iss_src1,
    output logic [rs_div_pkg::DATA_W-1:0] iss_src2
);

    logic [rs_div_pkg::RS_ENTRIES-1:0] free_vec;
    logic [rs_div_pkg::RS_ENTRIES-1:0] ready_vec;
    logic [rs_div_pkg::RS_ENTRIES-1:0] free_grant;
    logic [rs_div_pkg::RS_ENTRIES-1:0] issue_grant;
    logic                              issue_any;
    logic                              issue_take;
    logic                              alloc_en;
    logic [rs_div_pkg::PC_W-1:0]       sel_pc;
    logic [rs_div_pkg::TAG_W-1:0]      sel_rd;
    rs_div_pkg::div_op_e               sel_op;
    logic [rs_div_pkg::DATA_W-1:0]     sel_src1;
    logic [rs_div_pkg::DATA_W-1:0]     sel_src2;

    assign alloc_en = disp_valid && disp_ready;

    rs_div_entries i_entries (
        .clk(clk), .reset(reset),
        .alloc_en(alloc_en), .alloc_grant(free_grant),
        .disp_pc(disp_pc), .disp_rd(disp_rd), .disp_op(disp_op),
        .disp_src1_tag(disp_src1_tag), .disp_src1_data(disp_src1_data),
        .disp_src1_valid(disp_src1_valid),
        .disp_src2_tag(disp_src2_tag), .disp_src2_data(disp_src2_data),
        .disp_src2_valid(disp_src2_valid),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
        .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
        .issue_take(issue_take), .issue_grant(issue_grant),
        .free_vec(free_vec), .ready_vec(ready_vec),
        .sel_pc(sel_pc), .sel_rd(sel_rd), .sel_op(sel_op),
        .sel_src1(sel_src1), .sel_src2(sel_src2)
    );

    // oldest-agnostic, lowest index ready entry issues
    rs_div_priority_select sel_issue (
        .req(ready_vec), .grant(issue_grant), .any(issue_any)
    );

    rs_div_priority_select sel_free (
        .req(free_vec), .grant(free_grant), .any(disp_ready)
    );

    rs_div_issue_reg i_issue_reg (
        .clk(clk), .reset(reset),
        .cand_valid(issue_any), .cand_pc(sel_pc), .cand_rd(sel_rd),
        .cand_op(sel_op), .cand_src1(sel_src1), .cand_src2(sel_src2),
        .iss_ready(iss_ready), .take(issue_take),
        .iss_valid(iss_valid), .iss_pc(iss_pc), .iss_rd(iss_rd),
        .iss_op(iss_op), .iss_src1(iss_src1), .iss_src2(iss_src2)
    );

endmodule

`default_nettype wire

//--- sim/rs_div_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div_checker (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic                          iss_valid,
    input wire logic                          iss_ready,
    input wire logic [rs_div_pkg::PC_W-1:0]   iss_pc,
    input wire logic [rs_div_pkg::TAG_W-1:0]  iss_rd,
    input wire rs_div_pkg::div_op_e           iss_op,
    input wire logic [rs_div_pkg::DATA_W-1:0] iss_src1,
    input wire logic [rs_div_pkg::DATA_W-1:0] iss_src2
);

    // stalled output must not move
    a_hold: assert property (@(posedge clk) disable iff (reset)
        iss_valid && !iss_ready |=> iss_valid && $stable(iss_pc) && $stable(iss_rd)
            && $stable(iss_op) && $stable(iss_src1) && $stable(iss_src2))
        else $error("issue outputs changed while the divider stalled");

    a_reset_idle: assert property (@(posedge clk) reset |=> !iss_valid)
        else $error("iss_valid high right after reset");

    a_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(iss_valid))
        else $error("iss_valid is unknown");

endmodule

`default_nettype wire

//--- sim/rs_div_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rs_div_tb;

    localparam int TOTAL       = 300;
    localparam int CYCLE_LIMIT = TOTAL * 20;

    logic                          clk;
    logic                          reset;
    logic                          disp_valid;
    logic                          disp_ready;
    logic [rs_div_pkg::PC_W-1:0]   disp_pc;
    logic [rs_div_pkg::TAG_W-1:0]  disp_rd;
    rs_div_pkg::div_op_e           disp_op;
    logic [rs_div_pkg::TAG_W-1:0]  disp_src1_tag;
    logic [rs_div_pkg::DATA_W-1:0] disp_src1_data;
    logic                          disp_src1_valid;
    logic [rs_div_pkg::TAG_W-1:0]  disp_src2_tag;
    logic [rs_div_pkg::DATA_W-1:0] disp_src2_data;
    logic                          disp_src2_valid;
    logic                          alu_valid;
    logic [rs_div_pkg::TAG_W-1:0]  alu_tag;
    logic [rs_div_pkg::DATA_W-1:0] alu_data;
    logic                          mul_valid;
    logic [rs_div_pkg::TAG_W-1:0]  mul_tag;
    logic [rs_div_pkg::DATA_W-1:0] mul_data;
    logic                          iss_valid;
    logic                          iss_ready;
    logic [rs_div_pkg::PC_W-1:0]   iss_pc;
    logic [rs_div_pkg::TAG_W-1:0]  iss_rd;
    rs_div_pkg::div_op_e           iss_op;
    logic [rs_div_pkg::DATA_W-1:0] iss_src1;
    logic [rs_div_pkg::DATA_W-1:0] iss_src2;

    // reference model, keyed by rd
    bit                            pend   [int];
    logic [rs_div_pkg::PC_W-1:0]   exp_pc [int];
    logic [3:0]                    exp_op [int];
    logic [rs_div_pkg::DATA_W-1:0] exp_s1 [int];
    logic [rs_div_pkg::DATA_W-1:0] exp_s2 [int];

    // producer tags not yet broadcast
    logic [rs_div_pkg::TAG_W-1:0]  tag_q[$];
    bit                            tag_live[256];
    logic [rs_div_pkg::DATA_W-1:0] tag_val[256];
    logic [rs_div_pkg::TAG_W-1:0]  next_tag;

    int      errors;
    int      sent;
    int      accepted;
    int      issued;
    int      cycles;
    bit      acc;
    bit      timed_out;

    rs_div i_rs_div (.*);

    bind rs_div rs_div_checker i_checker (
        .clk(clk), .reset(reset), .iss_valid(iss_valid), .iss_ready(iss_ready),
        .iss_pc(iss_pc), .iss_rd(iss_rd), .iss_op(iss_op),
        .iss_src1(iss_src1), .iss_src2(iss_src2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic finish_run();
        $display("errors %0d  dispatched %0d  issued %0d", errors, accepted, issued);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [rs_div_pkg::TAG_W-1:0] new_tag();
        logic [rs_div_pkg::TAG_W-1:0] t;
        t = next_tag;
        while (tag_live[t]) begin
            t++;
        end
        next_tag   = t + 8'd1;
        tag_live[t] = 1'b1;
        tag_val[t]  = $urandom;
        tag_q.push_back(t);
        return t;
    endfunction

    // mode 0 valid, 1 random, 2 waits on a fresh tag
    task automatic pick_operand(input int mode, output logic v,
                                output logic [rs_div_pkg::TAG_W-1:0] t,
                                output logic [rs_div_pkg::DATA_W-1:0] d);
        int r;
        r = (mode == 0) ? 0 : (mode == 2) ? 2 : int'($urandom_range(2));
        d = $urandom; // junk when waiting
        t = 8'($urandom);
        v = (r == 0);
        if (r == 1 && tag_q.size() > 0) begin
            t = tag_q[$urandom_range(tag_q.size() - 1)];
        end else if (r != 0) begin
            t = new_tag();
        end
    endtask

    task automatic make_instr(input int mode);
        logic [3:0] op_bits;
        op_bits    = 4'($urandom_range(3));
        disp_valid = 1'b1;
        disp_pc    = $urandom;
        disp_rd    = 8'(sent);
        disp_op    = rs_div_pkg::div_op_e'(op_bits);
        pick_operand(mode, disp_src1_valid, disp_src1_tag, disp_src1_data);
        pick_operand((mode == 2) ? 1 : mode, disp_src2_valid, disp_src2_tag, disp_src2_data);
        sent++;
    endtask

    task automatic record_dispatch();
        int key;
        key = int'(disp_rd);
        assert (!pend.exists(key)) else begin
            errors++;
            $display("rd %0h dispatched again while still pending", disp_rd);
        end
        pend[key]   = 1'b1;
        exp_pc[key] = disp_pc;
        exp_op[key] = disp_op;
        exp_s1[key] = disp_src1_valid ? disp_src1_data : tag_val[disp_src1_tag];
        exp_s2[key] = disp_src2_valid ? disp_src2_data : tag_val[disp_src2_tag];
        accepted++;
    endtask

    task automatic check_issue();
        int key;
        key = int'(iss_rd);
        assert (pend.exists(key)) else begin
            errors++;
            $display("issued rd %0h was not pending", iss_rd);
        end
        if (pend.exists(key)) begin
            check_value("iss_pc", exp_pc[key], iss_pc);
            check_value("iss_op", 32'(exp_op[key]), 32'(iss_op));
            check_value("iss_src1", exp_s1[key], iss_src1);
            check_value("iss_src2", exp_s2[key], iss_src2);
            pend.delete(key);
            issued++;
        end
    endtask

    // a held dispatch must not lose the broadcast it waits on
    task automatic claim_tag(output bit ok, output logic [rs_div_pkg::TAG_W-1:0] t);
        int idx;
        ok = 1'b0;
        t  = '0;
        if (tag_q.size() > 0) begin
            idx = int'($urandom_range(tag_q.size() - 1));
            t   = tag_q[idx];
            ok  = acc || !disp_valid ||
                  !((!disp_src1_valid && disp_src1_tag == t) ||
                    (!disp_src2_valid && disp_src2_tag == t));
            if (ok) begin
                tag_q.delete(idx);
                tag_live[t] = 1'b0;
            end
        end
    endtask

    task automatic broadcast();
        int mode;
        bit ok;
        logic [rs_div_pkg::TAG_W-1:0] t;
        mode = int'($urandom_range(9));
        if (mode < 8) begin
            claim_tag(ok, t);
            if (ok && (mode < 3 || mode >= 6)) begin
                alu_valid = 1'b1;
                alu_tag   = t;
                alu_data  = tag_val[t];
            end
            if (ok && mode == 7) begin
                claim_tag(ok, t); // second, different tag
            end
            if (ok && mode >= 3) begin
                mul_valid = 1'b1;
                mul_tag   = t;
                mul_data  = tag_val[t];
            end
        end
    endtask

    // one clock of stimulus, disp_mode -1 offers nothing new
    task automatic step(input int disp_mode, input int ready_pct, input bit bcast_en);
        @(posedge clk);
        #1;
        if (acc) begin
            disp_valid = 1'b0;
        end
        iss_ready = ($urandom_range(99) < ready_pct);
        if (iss_valid && iss_ready) begin
            check_issue();
        end
        if (!disp_valid && disp_mode >= 0 && sent < TOTAL) begin
            make_instr(disp_mode);
        end
        acc = disp_valid && disp_ready; // disp_ready is settled here
        if (acc) begin
            record_dispatch();
        end
        alu_valid = 1'b0;
        mul_valid = 1'b0;
        if (bcast_en) begin
            broadcast();
        end
    endtask

    initial begin
        timed_out = 1'b0;
        cycles    = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = 1'b1;
        $display("timeout after %0d cycles with %0d instructions pending", cycles, pend.size());
        finish_run();
    end

    initial begin
        int edges;
        int mark;
        void'($urandom(36));
        errors = 0;
        sent = 0;
        accepted = 0;
        issued = 0;
        acc = 1'b0;
        next_tag = '0;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_pc = '0;
        disp_rd = '0;
        disp_op = rs_div_pkg::OP_DIV;
        disp_src1_tag = '0;
        disp_src1_data = '0;
        disp_src1_valid = 1'b0;
        disp_src2_tag = '0;
        disp_src2_data = '0;
        disp_src2_valid = 1'b0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_data = '0;
        mul_valid = 1'b0;
        mul_tag = '0;
        mul_data = '0;
        iss_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // latency into an empty station
        step(0, 100, 1'b0);
        assert (acc) else begin
            errors++;
            $display("dispatch into an empty station was not accepted");
        end
        edges = 1; // accepting edge
        step(-1, 100, 1'b0);
        while (!iss_valid && edges < 10) begin
            step(-1, 100, 1'b0);
            edges++;
        end
        assert (edges == 2) else begin
            errors++;
            $display("iss_valid rose %0d edges after dispatch instead of 2", edges);
        end
        while (pend.size() > 0) begin
            step(-1, 100, 1'b0);
        end

        // fill all eight entries under back-pressure
        mark = accepted;
        while (accepted < mark + 8) begin
            step(2, 0, 1'b0);
        end
        step(-1, 0, 1'b0);
        check_value("disp_ready", 32'd0, 32'(disp_ready));
        mark = issued;
        while (issued == mark) begin
            step(-1, 100, 1'b1);
        end
        step(-1, 100, 1'b1);
        check_value("disp_ready", 32'd1, 32'(disp_ready));

        // random traffic, then drain
        while (sent < TOTAL) begin
            step(1, 70, 1'b1);
        end
        while (pend.size() > 0 || (disp_valid && !acc)) begin
            step(-1, 70, 1'b1);
        end
        step(-1, 0, 1'b0);
        assert (accepted == TOTAL && issued == TOTAL) else begin
            errors++;
            $display("only %0d of %0d instructions went through", issued, TOTAL);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- flist.f
design/rs_div_pkg.sv
design/rs_div_priority_select.sv
design/rs_div_entries.sv
design/rs_div_issue_reg.sv
design/rs_div.sv
sim/rs_div_checker.sv
sim/rs_div_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rs_div_tb -f flist.f -o rs_div_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/rs_div_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
